// ==== source/tilevid_pkg.sv ====
package tilevid_pkg;

    // Pixel-enable steps from timer position to mixer output
    localparam int PXL_DLY = 10;

    // Tile ROM address is code * 8 + row
    localparam int ROM_AW = 12;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
    } vid_timing_t;

    // Word address, write data and active-low byte lanes
    typedef struct packed {
        logic [10:0] addr;
        logic [15:0] dout;
        logic [ 1:0] dsn;
    } cpu_bus_t;

    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic       unused;
            logic [4:0] blue;
            logic [4:0] green;
            logic [4:0] red;
        } col;
    } pal_word_u;

    typedef struct packed {
        logic [1:0] spare;
        logic [4:0] color;
        logic [8:0] code;
    } tile_entry_t;

    // Word after a byte-lane write, as the CPU reads it back
    function automatic logic [15:0] byte_merge(
        input logic [15:0] old,
        input logic [15:0] din,
        input logic [ 1:0] dsn
    );
        logic [15:0] w;
        w = old;
        if (!dsn[1]) w[15:8] = din[15:8];
        if (!dsn[0]) w[ 7:0] = din[ 7:0];
        return w;
    endfunction

endpackage

// ==== source/tilevid_timer.sv ====
`timescale 1ns/1ps

module tilevid_timer #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 384,
    parameter int HS_START = 288,
    parameter int HS_LEN   = 32,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262,
    parameter int VS_START = 234,
    parameter int VS_LEN   = 3
)(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,
    output tilevid_pkg::vid_timing_t timing,
    output logic                     vint
);
    import tilevid_pkg::*;

    vid_timing_t tm;
    logic [8:0]  h_nxt;
    logic [8:0]  v_nxt;
    logic        line_end;

    assign line_end = tm.hdump == 9'(H_TOTAL - 1);

    // Raster position for the next pixel step
    always_comb begin
        h_nxt = line_end ? 9'd0 : tm.hdump + 9'd1;
        v_nxt = tm.vdump;
        if (line_end) begin
            v_nxt = (tm.vdump == 9'(V_TOTAL - 1)) ? 9'd0 : tm.vdump + 9'd1;
        end
    end

    // Flags are derived from the next position so they line up with hdump/vdump
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tm   <= '0;
            vint <= 1'b0;
        end else begin
            vint <= pxl_cen && h_nxt == 9'd0 && v_nxt == 9'(V_ACTIVE);
            if (pxl_cen) begin
                tm.hdump <= h_nxt;
                tm.vdump <= v_nxt;
                tm.lhbl  <= h_nxt < 9'(H_ACTIVE);
                tm.lvbl  <= v_nxt < 9'(V_ACTIVE);
                tm.hs    <= h_nxt >= 9'(HS_START) && h_nxt < 9'(HS_START + HS_LEN);
                tm.vs    <= v_nxt >= 9'(VS_START) && v_nxt < 9'(VS_START + VS_LEN);
            end
        end
    end

    assign timing = tm;

endmodule

// ==== source/tilevid_mmr.sv ====
`timescale 1ns/1ps

module tilevid_mmr (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mmr_cs,
    input  tilevid_pkg::cpu_bus_t cpu,
    output logic [15:0]           mmr_dout,
    output logic [ 8:0]           hscroll,
    output logic [ 7:0]           vscroll,
    output logic                  layer_en
);
    import tilevid_pkg::*;

    logic [15:0] cur;
    logic [15:0] wr;
    logic [15:0] rd_nxt;

    // Current word, merged write data and the value it reads back as
    always_comb begin
        case (cpu.addr[1:0])
            2'd0:    cur = {7'd0, hscroll};
            2'd1:    cur = {8'd0, vscroll};
            2'd2:    cur = {15'd0, layer_en};
            default: cur = 16'd0;
        endcase
        wr = byte_merge(cur, cpu.dout, cpu.dsn);
        case (cpu.addr[1:0])
            2'd0:    rd_nxt = {7'd0, wr[8:0]};
            2'd1:    rd_nxt = {8'd0, wr[7:0]};
            2'd2:    rd_nxt = {15'd0, wr[0]};
            default: rd_nxt = 16'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hscroll  <= 9'd0;
            vscroll  <= 8'd0;
            layer_en <= 1'b1;
        end else if (mmr_cs) begin
            case (cpu.addr[1:0])
                2'd0:    hscroll  <= wr[8:0];
                2'd1:    vscroll  <= wr[7:0];
                2'd2:    layer_en <= wr[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mmr_cs) mmr_dout <= rd_nxt;
    end

endmodule

// ==== source/tilevid_tilemap.sv ====
`timescale 1ns/1ps

module tilevid_tilemap (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              pxl_cen,

    input  logic                              char_cs,
    input  tilevid_pkg::cpu_bus_t             cpu,
    output logic [15:0]                       char_dout,

    input  tilevid_pkg::vid_timing_t          timing,
    input  logic [8:0]                        hscroll,
    input  logic [7:0]                        vscroll,
    input  logic                              layer_en,

    output logic [tilevid_pkg::ROM_AW-1:0]    rom_addr,
    input  logic [31:0]                       rom_data,

    output logic [8:0]                        pxl
);
    import tilevid_pkg::*;

    // Map read, ROM request and shifter load
    localparam int FETCH_STG = 3;
    localparam int OUT_DLY   = PXL_DLY - 2 - FETCH_STG;

    tile_entry_t map_ram [0:2047];
    tile_entry_t map_q;

    logic [ 8:0] sx;
    logic [ 7:0] sy;
    logic [10:0] map_addr;

    logic        ld1;
    logic        ld2;
    logic [ 2:0] off1;
    logic [ 2:0] off2;
    logic [ 2:0] row1;
    logic [ 4:0] color2;
    logic [ 4:0] color_sh;
    logic [31:0] shifter;
    logic [ 8:0] dly [0:OUT_DLY-1];

    // Scrolled position wraps at 512 x 256
    assign sx       = timing.hdump + hscroll;
    assign sy       = timing.vdump[7:0] + vscroll;
    assign map_addr = {sy[7:3], sx[8:3]};

    // CPU side of the map RAM
    always_ff @(posedge clk) begin
        if (char_cs) begin
            if (!cpu.dsn[1]) map_ram[cpu.addr][15:8] <= cpu.dout[15:8];
            if (!cpu.dsn[0]) map_ram[cpu.addr][ 7:0] <= cpu.dout[ 7:0];
            char_dout <= byte_merge(map_ram[cpu.addr], cpu.dout, cpu.dsn);
        end
    end

    // Video side, one entry per pixel step
    always_ff @(posedge clk) begin
        if (pxl_cen) map_q <= map_ram[map_addr];
    end

    // A tile is fetched at every tile edge and again at the start of the
    // line, where the first tile is only partly shown
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld1  <= 1'b0;
            ld2  <= 1'b0;
            off1 <= 3'd0;
            off2 <= 3'd0;
            row1 <= 3'd0;
        end else if (pxl_cen) begin
            ld1  <= timing.hdump == 9'd0 || sx[2:0] == 3'd0;
            off1 <= sx[2:0];
            row1 <= sy[2:0];
            ld2  <= ld1;
            off2 <= off1;
        end
    end

    // ROM row request, data comes back before the next pixel step
    // (pxl_cen is never high on two clk cycles in a row)
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rom_addr <= {map_q.code, row1};
            color2   <= map_q.color;
            if (ld2) begin
                // Skip the pixels left of the scroll offset
                shifter  <= rom_data << {off2, 2'b00};
                color_sh <= color2;
            end else begin
                shifter <= shifter << 4;
            end
        end
    end

    // Line up with the mixer input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < OUT_DLY; k++) begin
                dly[k] <= 9'd0;
            end
        end else if (pxl_cen) begin
            dly[0] <= layer_en ? {color_sh, shifter[31:28]} : 9'd0;
            for (int k = 1; k < OUT_DLY; k++) begin
                dly[k] <= dly[k-1];
            end
        end
    end

    assign pxl = dly[OUT_DLY-1];

endmodule

// ==== source/tilevid_colmix.sv ====
`timescale 1ns/1ps

module tilevid_colmix (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,

    input  logic                     pal_cs,
    input  tilevid_pkg::cpu_bus_t    cpu,
    output logic [15:0]              pal_dout,

    input  tilevid_pkg::vid_timing_t timing,
    input  logic [8:0]               pxl,

    output logic [4:0]               red,
    output logic [4:0]               green,
    output logic [4:0]               blue,
    output logic                     lhbl_dly,
    output logic                     lvbl_dly
);
    import tilevid_pkg::*;

    pal_word_u          pal_ram [0:511];
    pal_word_u          pal_q;
    logic [8:0]         pal_idx;
    logic [PXL_DLY-1:0] hb_sr;
    logic [PXL_DLY-1:0] vb_sr;
    logic               show;

    // Nibble zero is transparent and shows the backdrop
    assign pal_idx = (pxl[3:0] == 4'd0) ? 9'd0 : pxl;

    always_ff @(posedge clk) begin
        if (pal_cs) begin
            if (!cpu.dsn[1]) pal_ram[cpu.addr[8:0]].raw[15:8] <= cpu.dout[15:8];
            if (!cpu.dsn[0]) pal_ram[cpu.addr[8:0]].raw[ 7:0] <= cpu.dout[ 7:0];
            pal_dout <= byte_merge(pal_ram[cpu.addr[8:0]].raw, cpu.dout, cpu.dsn);
        end
        if (pxl_cen) pal_q <= pal_ram[pal_idx];
    end

    // Blanking follows the pixel through the whole pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hb_sr <= '0;
            vb_sr <= '0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[PXL_DLY-2:0], timing.lhbl};
            vb_sr <= {vb_sr[PXL_DLY-2:0], timing.lvbl};
        end
    end

    // Blank flags that go out together with this colour
    assign show = hb_sr[PXL_DLY-2] & vb_sr[PXL_DLY-2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red   <= 5'd0;
            green <= 5'd0;
            blue  <= 5'd0;
        end else if (pxl_cen) begin
            red   <= show ? pal_q.col.red   : 5'd0;
            green <= show ? pal_q.col.green : 5'd0;
            blue  <= show ? pal_q.col.blue  : 5'd0;
        end
    end

    assign lhbl_dly = hb_sr[PXL_DLY-1];
    assign lvbl_dly = vb_sr[PXL_DLY-1];

endmodule

// ==== source/tilevid_video.sv ====
`timescale 1ns/1ps

module tilevid_video #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 384,
    parameter int HS_START = 288,
    parameter int HS_LEN   = 32,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262,
    parameter int VS_START = 234,
    parameter int VS_LEN   = 3
)(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              pxl_cen,

    // CPU interface
    input  logic                              char_cs,
    input  logic                              pal_cs,
    input  logic                              mmr_cs,
    input  tilevid_pkg::cpu_bus_t             cpu,
    output logic [15:0]                       char_dout,
    output logic [15:0]                       pal_dout,
    output logic [15:0]                       mmr_dout,
    output logic                              vint,

    // Graphics ROM
    output logic [tilevid_pkg::ROM_AW-1:0]    rom_addr,
    input  logic [31:0]                       rom_data,

    // Video out
    output logic                              hs,
    output logic                              vs,
    output logic                              lhbl_dly,
    output logic                              lvbl_dly,
    output logic [4:0]                        red,
    output logic [4:0]                        green,
    output logic [4:0]                        blue
);
    import tilevid_pkg::*;

    vid_timing_t timing;
    logic [8:0]  hscroll;
    logic [7:0]  vscroll;
    logic        layer_en;
    logic [8:0]  char_pxl;

    assign hs = timing.hs;
    assign vs = timing.vs;

    tilevid_timer #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .HS_START ( HS_START ),
        .HS_LEN   ( HS_LEN   ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .VS_START ( VS_START ),
        .VS_LEN   ( VS_LEN   )
    ) u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .timing   ( timing   ),
        .vint     ( vint     )
    );

    tilevid_mmr u_mmr (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .mmr_cs   ( mmr_cs   ),
        .cpu      ( cpu      ),
        .mmr_dout ( mmr_dout ),
        .hscroll  ( hscroll  ),
        .vscroll  ( vscroll  ),
        .layer_en ( layer_en )
    );

    tilevid_tilemap u_tilemap (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .char_cs   ( char_cs   ),
        .cpu       ( cpu       ),
        .char_dout ( char_dout ),
        .timing    ( timing    ),
        .hscroll   ( hscroll   ),
        .vscroll   ( vscroll   ),
        .layer_en  ( layer_en  ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .pxl       ( char_pxl  )
    );

    tilevid_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pal_cs   ( pal_cs   ),
        .cpu      ( cpu      ),
        .pal_dout ( pal_dout ),
        .timing   ( timing   ),
        .pxl      ( char_pxl ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

endmodule

// ==== tb/tilevid_video_tb.sv ====
`timescale 1ns/1ps

module tilevid_video_tb;
    import tilevid_pkg::*;

    localparam int H_ACTIVE   = 64;
    localparam int H_TOTAL    = 96;
    localparam int HS_START   = 72;
    localparam int HS_LEN     = 8;
    localparam int V_ACTIVE   = 16;
    localparam int V_TOTAL    = 24;
    localparam int VS_START   = 18;
    localparam int VS_LEN     = 2;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * 2;
    // Map and palette fill plus register and byte-lane accesses
    localparam int SETUP_CLKS = 2048 + 512 + 64;
    localparam int MAX_CYCLES = (3 * FRAME_CLKS + SETUP_CLKS) * 3 / 2;

    logic              clk      = 1'b0;
    logic              rst_n    = 1'b0;
    logic              pxl_cen  = 1'b0;
    logic              char_cs  = 1'b0;
    logic              pal_cs   = 1'b0;
    logic              mmr_cs   = 1'b0;
    cpu_bus_t          cpu      = '0;
    logic [31:0]       rom_data = '0;
    logic [15:0]       char_dout;
    logic [15:0]       pal_dout;
    logic [15:0]       mmr_dout;
    logic              vint;
    logic [ROM_AW-1:0] rom_addr;
    logic              hs;
    logic              vs;
    logic              lhbl_dly;
    logic              lvbl_dly;
    logic [4:0]        red;
    logic [4:0]        green;
    logic [4:0]        blue;

    // Testbench copies of map, palette, registers and ROM
    logic [15:0]       map_sh [0:2047];
    logic [15:0]       pal_sh [0:511];
    logic [31:0]       rom    [0:(1 << ROM_AW) - 1];
    logic [8:0]        hscroll_sh = 9'd0;
    logic [7:0]        vscroll_sh = 8'd0;
    logic              en_sh      = 1'b1;
    logic              check_on   = 1'b0;
    logic [31:0]       lfsr       = 32'h7e3c_9efe;

    int   cycles     = 0;
    int   mon_errors = 0;
    int   cpu_errors = 0;
    int   ref_h      = 0;
    int   ref_v      = 0;
    logic stepped    = 1'b0;
    int   px         = 0;
    int   py         = 0;
    int   last_vint  = -1;
    logic prev_act   = 1'b0;
    logic prev_lv    = 1'b0;
    logic armed      = 1'b0;

    tilevid_video #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .HS_START ( HS_START ),
        .HS_LEN   ( HS_LEN   ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .VS_START ( VS_START ),
        .VS_LEN   ( VS_LEN   )
    ) dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .char_cs   ( char_cs   ),
        .pal_cs    ( pal_cs    ),
        .mmr_cs    ( mmr_cs    ),
        .cpu       ( cpu       ),
        .char_dout ( char_dout ),
        .pal_dout  ( pal_dout  ),
        .mmr_dout  ( mmr_dout  ),
        .vint      ( vint      ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    // Graphics ROM answering one clock after the address
    always @(negedge clk) begin
        rom_data <= rom[rom_addr];
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Returns 1 when the value is wrong
    function automatic int compare(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        int bad;
        bad = 0;
        assert (act == exp) else begin
            $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            bad = 1;
        end
        return bad;
    endfunction

    function automatic logic [15:0] lane_merge(input logic [15:0] old, input logic [15:0] din,
                                               input logic [1:0] dsn);
        logic [15:0] mask;
        mask = {{8{~dsn[1]}}, {8{~dsn[0]}}};
        return (old & ~mask) | (din & mask);
    endfunction

    function automatic logic [15:0] mmr_word(input logic [10:0] addr);
        case (addr[1:0])
            2'd0:    return {7'd0, hscroll_sh};
            2'd1:    return {8'd0, vscroll_sh};
            2'd2:    return {15'd0, en_sh};
            default: return 16'd0;
        endcase
    endfunction

    function automatic logic [15:0] mmr_mask(input logic [10:0] addr);
        case (addr[1:0])
            2'd0:    return 16'h01ff;
            2'd1:    return 16'h00ff;
            2'd2:    return 16'h0001;
            default: return 16'h0000;
        endcase
    endfunction

    // Expected {red, green, blue} for screen column x of line y
    function automatic logic [14:0] ref_color(input int x, input int y);
        logic [8:0]  sx;
        logic [7:0]  sy;
        tile_entry_t ent;
        logic [31:0] row;
        logic [3:0]  nib;
        logic [8:0]  idx;
        logic [15:0] pw;
        int          sh;
        sx  = 9'(x) + hscroll_sh;
        sy  = 8'(y) + vscroll_sh;
        ent = map_sh[{sy[7:3], sx[8:3]}];
        row = rom[{ent.code, sy[2:0]}];
        // Leftmost pixel sits in the top nibble
        sh  = 28 - 4 * int'(sx[2:0]);
        nib = 4'(row >> sh);
        idx = (nib == 4'd0 || !en_sh) ? 9'd0 : {ent.color, nib};
        pw  = pal_sh[idx];
        return {pw[4:0], pw[9:5], pw[14:10]};
    endfunction

    // One strobed access with the read data checked on the next clock
    task automatic access(input int region, input logic [10:0] addr,
                          input logic [15:0] data, input logic [1:0] dsn);
        logic [15:0] old;
        logic [15:0] exp;
        logic [15:0] got;
        case (region)
            0:       old = map_sh[addr];
            1:       old = pal_sh[addr[8:0]];
            default: old = mmr_word(addr);
        endcase
        exp = lane_merge(old, data, dsn);
        if (region == 2) exp = exp & mmr_mask(addr);
        cpu.addr = addr;
        cpu.dout = data;
        cpu.dsn  = dsn;
        char_cs  = region == 0;
        pal_cs   = region == 1;
        mmr_cs   = region == 2;
        @(negedge clk);
        char_cs = 1'b0;
        pal_cs  = 1'b0;
        mmr_cs  = 1'b0;
        case (region)
            0: begin
                got = char_dout;
                map_sh[addr] = exp;
                cpu_errors += compare("char_dout", 32'(exp), 32'(got));
            end
            1: begin
                got = pal_dout;
                pal_sh[addr[8:0]] = exp;
                cpu_errors += compare("pal_dout", 32'(exp), 32'(got));
            end
            default: begin
                got = mmr_dout;
                if (addr[1:0] == 2'd0) hscroll_sh = exp[8:0];
                if (addr[1:0] == 2'd1) vscroll_sh = exp[7:0];
                if (addr[1:0] == 2'd2) en_sh = exp[0];
                cpu_errors += compare("mmr_dout", 32'(exp), 32'(got));
            end
        endcase
    endtask

    task automatic lane_test(input int region, input logic [10:0] addr);
        access(region, addr, 16'(rand_bits(16)), 2'b01);
        access(region, addr, 16'(rand_bits(16)), 2'b10);
        access(region, addr, 16'(rand_bits(16)), 2'b11);
    endtask

    task automatic wait_vint();
        @(negedge clk);
        while (!vint) @(negedge clk);
    endtask

    // Pixels are compared from one vint to the next
    task automatic check_frame();
        check_on = 1'b1;
        wait_vint();
        check_on = 1'b0;
    endtask

    // Reference raster position stepped on each pixel enable
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_h   <= 0;
            ref_v   <= 0;
            stepped <= 1'b0;
        end else begin
            stepped <= pxl_cen;
            if (pxl_cen) begin
                if (ref_h == H_TOTAL - 1) begin
                    ref_h <= 0;
                    ref_v <= (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
                end else begin
                    ref_h <= ref_h + 1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            mon_errors += compare("hs",
                32'(ref_h >= HS_START && ref_h < HS_START + HS_LEN), 32'(hs));
            mon_errors += compare("vs",
                32'(ref_v >= VS_START && ref_v < VS_START + VS_LEN), 32'(vs));
            mon_errors += compare("vint",
                32'(stepped && ref_h == 0 && ref_v == V_ACTIVE), 32'(vint));
            if (vint) begin
                if (last_vint >= 0) begin
                    mon_errors += compare("vint period", FRAME_CLKS, cycles - last_vint);
                end
                last_vint = cycles;
            end
            // Once per pixel step right after the enabled edge
            if (stepped) begin
                if (lhbl_dly && lvbl_dly) begin
                    if (check_on) begin
                        mon_errors += compare("rgb", 32'(ref_color(px, py)),
                                              32'({red, green, blue}));
                    end
                    px++;
                end else begin
                    mon_errors += compare("rgb", 0, 32'({red, green, blue}));
                    if (prev_act) begin
                        if (armed) mon_errors += compare("active pixels per line", H_ACTIVE, px);
                        px = 0;
                        py++;
                    end
                end
                if (prev_lv && !lvbl_dly) begin
                    if (armed) mon_errors += compare("active lines per frame", V_ACTIVE, py);
                    armed = 1'b1;
                    py    = 0;
                end
                prev_act = lhbl_dly && lvbl_dly;
                prev_lv  = lvbl_dly;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Run stopped after %0d clock cycles before the tests ended", cycles);
            $display("Errors: display %0d, cpu port %0d", mon_errors, cpu_errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        tile_entry_t ent;
        for (int i = 0; i < (1 << ROM_AW); i++) begin
            rom[i] = rand_bits(32);
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // Register values after reset
        for (int r = 0; r < 4; r++) begin
            access(2, 11'(r), 16'hffff, 2'b11);
        end
        for (int i = 0; i < 2048; i++) begin
            ent.spare = 2'(rand_bits(2));
            ent.color = 5'(rand_bits(5));
            ent.code  = 9'(rand_bits(9));
            access(0, 11'(i), ent, 2'b00);
        end
        for (int i = 0; i < 512; i++) begin
            access(1, 11'(i), 16'(rand_bits(16)), 2'b00);
        end
        lane_test(0, 11'(rand_bits(11)));
        lane_test(1, 11'(rand_bits(9)));
        for (int r = 0; r < 4; r++) begin
            lane_test(2, 11'(r));
        end
        // Random scroll
        access(2, 11'd0, 16'(rand_bits(16)), 2'b00);
        access(2, 11'd1, 16'(rand_bits(16)), 2'b00);
        access(2, 11'd2, 16'h0001, 2'b00);
        wait_vint();
        check_frame();
        // Scroll near both wrap points
        access(2, 11'd0, 16'(9'd480 + 9'(rand_bits(5))), 2'b00);
        access(2, 11'd1, 16'(8'd248 + 8'(rand_bits(3))), 2'b00);
        check_frame();
        access(2, 11'd2, 16'h0000, 2'b00);
        check_frame();
        $display("Errors: display %0d, cpu port %0d", mon_errors, cpu_errors);
        if (mon_errors + cpu_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tilevid_video.f ====
source/tilevid_pkg.sv
source/tilevid_timer.sv
source/tilevid_mmr.sv
source/tilevid_tilemap.sv
source/tilevid_colmix.sv
source/tilevid_video.sv
tb/tilevid_video_tb.sv

// ==== Makefile ====
TOP = tilevid_video_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tilevid_video.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
